// File: rtl/acc_types_pkg.sv
package acc_types_pkg;

  //////////////////////////////
  // Data path sizes
  //////////////////////////////

  localparam int DATA_WIDTH   = 32;
  localparam int MAX_PIXELS   = 64;
  localparam int MAX_CHANNELS = 16;

  // Buffer address covers 0..MAX_PIXELS-1
  localparam int PIX_ADDR_WIDTH = $clog2(MAX_PIXELS);

  // Counts need one more bit to hold the maximum itself
  localparam int PIX_IDX_WIDTH  = PIX_ADDR_WIDTH + 1;
  localparam int CHAN_IDX_WIDTH = $clog2(MAX_CHANNELS) + 1;

  //////////////////////////////
  // Data path types
  //////////////////////////////

  // Pixel or running sum, wraps on overflow
  typedef logic signed [DATA_WIDTH-1:0] pxl_t;

  typedef logic [PIX_IDX_WIDTH-1:0] pix_idx_t;

  typedef logic [CHAN_IDX_WIDTH-1:0] chan_idx_t;

  // One stream beat with its strobe
  typedef struct packed {
    logic valid;
    pxl_t data;
  } pxl_beat_t;

endpackage

// File: rtl/acc_cfg_pkg.sv
package acc_cfg_pkg;

  //////////////////////////////
  // Register map
  //////////////////////////////

  localparam int CFG_ADDR_WIDTH = 2;

  typedef logic [CFG_ADDR_WIDTH-1:0] cfg_addr_t;

  localparam cfg_addr_t CFG_ADDR_IMAGE_SIZE  = 2'd0;
  localparam cfg_addr_t CFG_ADDR_CHANNEL_NUM = 2'd1;

  // Lower limits, upper limits come from the buffer and channel sizes
  localparam int MIN_PIXELS   = 4;
  localparam int MIN_CHANNELS = 1;

  typedef struct packed {
    acc_types_pkg::pix_idx_t  image_size;
    acc_types_pkg::chan_idx_t channel_num;
  } cfg_t;

  // Full map and full channel count out of reset
  localparam cfg_t CFG_RESET = '{
    image_size:  acc_types_pkg::pix_idx_t'(acc_types_pkg::MAX_PIXELS),
    channel_num: acc_types_pkg::chan_idx_t'(acc_types_pkg::MAX_CHANNELS)
  };

endpackage

// File: rtl/acc_cfg_regs.sv
`timescale 1ns/10ps

module acc_cfg_regs (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   cfg_wr,
  input  acc_cfg_pkg::cfg_addr_t cfg_addr,
  input  acc_types_pkg::pxl_t    cfg_wdata,
  input  logic                   busy,
  output acc_cfg_pkg::cfg_t      cfg
);

  import acc_types_pkg::*;
  import acc_cfg_pkg::*;

  // Written value seen as unsigned, so negative values clamp high
  logic [DATA_WIDTH-1:0] wr_value;
  logic                  wr_ok;
  pix_idx_t              size_clamped;
  chan_idx_t             chan_clamped;

  assign wr_value = cfg_wdata;

  // Frame settings stay frozen while a frame runs
  assign wr_ok = cfg_wr && !busy;

  always_comb begin
    if (wr_value < DATA_WIDTH'(MIN_PIXELS)) begin
      size_clamped = pix_idx_t'(MIN_PIXELS);
    end else if (wr_value > DATA_WIDTH'(MAX_PIXELS)) begin
      size_clamped = pix_idx_t'(MAX_PIXELS);
    end else begin
      size_clamped = pix_idx_t'(wr_value);
    end
  end

  always_comb begin
    if (wr_value < DATA_WIDTH'(MIN_CHANNELS)) begin
      chan_clamped = chan_idx_t'(MIN_CHANNELS);
    end else if (wr_value > DATA_WIDTH'(MAX_CHANNELS)) begin
      chan_clamped = chan_idx_t'(MAX_CHANNELS);
    end else begin
      chan_clamped = chan_idx_t'(wr_value);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      cfg <= CFG_RESET;
    end else if (wr_ok) begin
      case (cfg_addr)
        CFG_ADDR_IMAGE_SIZE:  cfg.image_size  <= size_clamped;
        CFG_ADDR_CHANNEL_NUM: cfg.channel_num <= chan_clamped;
        default: ;
      endcase
    end
  end

endmodule

// File: rtl/partial_sum_buffer.sv
`timescale 1ns/10ps

module partial_sum_buffer (
  input  logic                    clk,
  input  logic                    rd_en,
  input  acc_types_pkg::pix_idx_t rd_addr,
  output acc_types_pkg::pxl_t     rd_data,
  input  logic                    wr_en,
  input  acc_types_pkg::pix_idx_t wr_addr,
  input  acc_types_pkg::pxl_t     wr_data
);

  import acc_types_pkg::*;

  //////////////////////////////
  // Storage
  //////////////////////////////

  // One running sum per pixel position of the map
  pxl_t mem [MAX_PIXELS];

  // Pixel indices never reach MAX_PIXELS, top bit dropped
  logic [PIX_ADDR_WIDTH-1:0] rd_index;
  logic [PIX_ADDR_WIDTH-1:0] wr_index;

  assign rd_index = rd_addr[PIX_ADDR_WIDTH-1:0];
  assign wr_index = wr_addr[PIX_ADDR_WIDTH-1:0];

  //////////////////////////////
  // Ports
  //////////////////////////////

  // Write back of the adder result
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_index] <= wr_data;
    end
  end

  // Registered read, data lines up with the delayed beat
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_index];
    end
  end

  // The read of a pixel always lands several cycles after its
  // previous write, since a map has at least MIN_PIXELS beats

endmodule

// File: rtl/sum_adder_stage.sv
`timescale 1ns/10ps

module sum_adder_stage (
  input  logic                     clk,
  input  logic                     reset,
  input  acc_types_pkg::pxl_beat_t add_in,
  input  acc_types_pkg::pxl_t      partial,
  input  logic                     first_chan,
  output acc_types_pkg::pxl_beat_t add_out
);

  import acc_types_pkg::*;

  logic valid_q;
  pxl_t sum_d;
  pxl_t sum_q;

  //////////////////////////////
  // Sum select
  //////////////////////////////

  // First channel starts a fresh sum, stale buffer data ignored
  always_comb begin
    if (first_chan) begin
      sum_d = add_in.data;
    end else begin
      sum_d = add_in.data + partial;
    end
  end

  //////////////////////////////
  // Output register
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= add_in.valid;
    end
  end

  // Data only loads with a beat
  always_ff @(posedge clk) begin
    if (add_in.valid) begin
      sum_q <= sum_d;
    end
  end

  assign add_out = '{valid: valid_q, data: sum_q};

endmodule

// File: rtl/channel_sum_ctrl.sv
`timescale 1ns/10ps

module channel_sum_ctrl (
  input  logic                     clk,
  input  logic                     reset,
  input  acc_cfg_pkg::cfg_t        cfg,
  input  acc_types_pkg::pxl_beat_t pxl_in,
  output logic                     rd_en,
  output acc_types_pkg::pix_idx_t  rd_addr,
  output logic                     wr_en,
  output acc_types_pkg::pix_idx_t  wr_addr,
  output acc_types_pkg::pxl_t      wr_data,
  output acc_types_pkg::pxl_beat_t add_in,
  output logic                     first_chan,
  input  acc_types_pkg::pxl_beat_t add_out,
  output acc_types_pkg::pxl_beat_t sum_out,
  output logic                     frame_done,
  output logic                     busy
);

  import acc_types_pkg::*;

  // Channel phase of the beats now arriving
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_FIRST,
    ST_MIDDLE,
    ST_LAST
  } phase_t;

  phase_t    state;
  phase_t    state_next;
  pix_idx_t  pix_cnt;
  chan_idx_t chan_cnt;
  logic      beat;
  logic      pix_wrap;
  logic      chan_first;
  logic      chan_last;
  logic      frame_end;

  // Stage 1, travels with add_in
  logic      s1_valid;
  pxl_t      s1_data;
  logic      s1_first;
  logic      s1_last;
  logic      s1_end;
  pix_idx_t  s1_addr;

  // Stage 2, travels with add_out
  logic      s2_last;
  logic      s2_end;
  pix_idx_t  s2_addr;
  logic      out_valid;

  //////////////////////////////
  // Counters and phase
  //////////////////////////////

  assign beat     = pxl_in.valid;
  assign pix_wrap = (pix_cnt == cfg.image_size - 1'b1);

  // Idle counts as first, a single channel is first and last at once
  assign chan_first = (state == ST_IDLE) || (state == ST_FIRST);
  assign chan_last  = (state == ST_LAST) ||
                      (chan_first && cfg.channel_num == chan_idx_t'(1));
  assign frame_end  = beat && pix_wrap && chan_last;

  always_comb begin
    state_next = state;
    if (beat) begin
      if (pix_wrap) begin
        if (chan_last) begin
          state_next = ST_IDLE;
        end else if (chan_cnt + 2'd2 == cfg.channel_num) begin
          state_next = ST_LAST;
        end else begin
          state_next = ST_MIDDLE;
        end
      end else if (state == ST_IDLE) begin
        state_next = ST_FIRST;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= ST_IDLE;
      pix_cnt  <= '0;
      chan_cnt <= '0;
    end else begin
      state <= state_next;
      if (beat) begin
        if (pix_wrap) begin
          pix_cnt  <= '0;
          chan_cnt <= chan_last ? '0 : chan_cnt + 1'b1;
        end else begin
          pix_cnt <= pix_cnt + 1'b1;
        end
      end
    end
  end

  // Nothing stored yet on the first channel
  assign rd_en   = beat && !chan_first;
  assign rd_addr = pix_cnt;

  //////////////////////////////
  // Pipeline
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      s1_valid <= 1'b0;
      s1_first <= 1'b0;
      s1_last  <= 1'b0;
      s1_end   <= 1'b0;
      s2_last  <= 1'b0;
      s2_end   <= 1'b0;
    end else begin
      s1_valid <= beat;
      s1_first <= chan_first;
      s1_last  <= chan_last;
      s1_end   <= frame_end;
      s2_last  <= s1_last;
      s2_end   <= s1_valid && s1_end;
    end
  end

  always_ff @(posedge clk) begin
    if (beat) begin
      s1_data <= pxl_in.data;
      s1_addr <= pix_cnt;
    end
    if (s1_valid) begin
      s2_addr <= s1_addr;
    end
  end

  assign add_in     = '{valid: s1_valid, data: s1_data};
  assign first_chan = s1_first;

  //////////////////////////////
  // Write back and output
  //////////////////////////////

  // Last channel goes out instead of back to the buffer
  assign wr_en   = add_out.valid && !s2_last;
  assign wr_addr = s2_addr;
  assign wr_data = add_out.data;

  assign out_valid  = add_out.valid && s2_last;
  assign sum_out    = '{valid: out_valid, data: out_valid ? add_out.data : '0};
  assign frame_done = add_out.valid && s2_end;

  // Stays up if the next frame already started behind the last beat
  always_ff @(posedge clk) begin
    if (reset) begin
      busy <= 1'b0;
    end else if (beat) begin
      busy <= 1'b1;
    end else if (frame_done && state == ST_IDLE) begin
      busy <= 1'b0;
    end
  end

endmodule

// File: rtl/channel_in_adder.sv
`timescale 1ns/10ps

module channel_in_adder (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     cfg_wr,
  input  acc_cfg_pkg::cfg_addr_t   cfg_addr,
  input  acc_types_pkg::pxl_t      cfg_wdata,
  input  acc_types_pkg::pxl_beat_t pxl_in,
  output acc_types_pkg::pxl_beat_t sum_out,
  output logic                     frame_done,
  output logic                     busy
);

  import acc_types_pkg::*;
  import acc_cfg_pkg::*;

  cfg_t      cfg;

  // Buffer ports
  logic      rd_en;
  pix_idx_t  rd_addr;
  pxl_t      rd_data;
  logic      wr_en;
  pix_idx_t  wr_addr;
  pxl_t      wr_data;

  // Adder ports
  pxl_beat_t add_in;
  pxl_beat_t add_out;
  logic      first_chan;

  //////////////////////////////
  // Configuration
  //////////////////////////////

  acc_cfg_regs u_regs (
    .clk      (clk),
    .reset    (reset),
    .cfg_wr   (cfg_wr),
    .cfg_addr (cfg_addr),
    .cfg_wdata(cfg_wdata),
    .busy     (busy),
    .cfg      (cfg)
  );

  //////////////////////////////
  // Control
  //////////////////////////////

  channel_sum_ctrl u_ctrl (
    .clk       (clk),
    .reset     (reset),
    .cfg       (cfg),
    .pxl_in    (pxl_in),
    .rd_en     (rd_en),
    .rd_addr   (rd_addr),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .add_in    (add_in),
    .first_chan(first_chan),
    .add_out   (add_out),
    .sum_out   (sum_out),
    .frame_done(frame_done),
    .busy      (busy)
  );

  //////////////////////////////
  // Data path
  //////////////////////////////

  partial_sum_buffer u_buf (
    .clk    (clk),
    .rd_en  (rd_en),
    .rd_addr(rd_addr),
    .rd_data(rd_data),
    .wr_en  (wr_en),
    .wr_addr(wr_addr),
    .wr_data(wr_data)
  );

  // Read data meets the delayed beat here
  sum_adder_stage u_adder (
    .clk       (clk),
    .reset     (reset),
    .add_in    (add_in),
    .partial   (rd_data),
    .first_chan(first_chan),
    .add_out   (add_out)
  );

endmodule

// File: dv/channel_in_adder_assertions.sv
`timescale 1ns/10ps

module channel_in_adder_assertions (
  input logic                     clk,
  input logic                     reset,
  input acc_types_pkg::pxl_beat_t pxl_in,
  input acc_types_pkg::pxl_beat_t sum_out,
  input logic                     frame_done,
  input logic                     busy
);

  //////////////////////////////
  // Output protocol
  //////////////////////////////

  // End of frame comes with the final sum
  a_done_with_sum: assert property (
    @(posedge clk) disable iff (reset)
    frame_done |-> sum_out.valid
  ) else $error("frame_done without sum_out.valid");

  // Two register stages from input to output
  a_sum_latency: assert property (
    @(posedge clk) disable iff (reset)
    sum_out.valid |-> $past(pxl_in.valid, 2)
  ) else $error("sum_out.valid without a valid pxl_in two cycles before");

  // Quiet outputs once reset is released
  a_quiet_after_reset: assert property (
    @(posedge clk)
    $fell(reset) |-> !busy && !sum_out.valid && !frame_done
  ) else $error("outputs active right after reset");

endmodule

bind channel_in_adder channel_in_adder_assertions u_assertions (
  .clk       (clk),
  .reset     (reset),
  .pxl_in    (pxl_in),
  .sum_out   (sum_out),
  .frame_done(frame_done),
  .busy      (busy)
);

// File: dv/channel_in_adder_tb.sv
`timescale 1ns/10ps

module channel_in_adder_tb;

  import acc_types_pkg::*;
  import acc_cfg_pkg::*;

  // Test row with written size and channel count, gap mode and mid-frame write
  typedef struct packed {
    logic [31:0] size_wr;
    logic [31:0] chan_wr;
    logic        gap;
    logic        mid_wr;
  } row_t;

  localparam int N_ROWS = 8;
  localparam int DONE_TIMEOUT = 64;
  localparam logic [31:0] MID_SIZE = 32'd6;

  // Out-of-range writes in rows 3 and 4
  localparam row_t ROWS [N_ROWS] = '{
    '{32'd16,  32'd4,  1'b0, 1'b0},
    '{32'd64,  32'd3,  1'b1, 1'b0},
    '{32'd8,   32'd1,  1'b0, 1'b0},
    '{32'd0,   32'd0,  1'b1, 1'b0},
    '{32'd100, 32'd20, 1'b0, 1'b0},
    '{32'd12,  32'd3,  1'b0, 1'b1},
    '{32'd5,   32'd2,  1'b1, 1'b0},
    '{32'd4,   32'd16, 1'b1, 1'b0}
  };

  logic      clk;
  logic      reset;
  logic      cfg_wr;
  cfg_addr_t cfg_addr;
  pxl_t      cfg_wdata;
  pxl_beat_t pxl_in;
  pxl_beat_t sum_out;
  logic      frame_done;
  logic      busy;

  int   seed = 32'h385b;
  int   cyc = 0;
  int   errors = 0;
  int   checks = 0;
  int   done_cnt = 0;
  int   out_cnt = 0;
  int   frame_size = 0;
  int   exp_cycle;
  int   row_idx;
  logic mon_on = 1'b0;
  logic frame_open = 1'b0;
  logic last_chan_beat;
  logic expect_done;

  pxl_t ref_sum [MAX_PIXELS];
  pxl_t exp_sum_q [$];
  int   exp_cycle_q [$];

  channel_in_adder uut (
    .clk       (clk),
    .reset     (reset),
    .cfg_wr    (cfg_wr),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .pxl_in    (pxl_in),
    .sum_out   (sum_out),
    .frame_done(frame_done),
    .busy      (busy)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  //////////////////////////////
  // Compare tasks
  //////////////////////////////

  task automatic check_pxl(input string name, input pxl_t got, input pxl_t exp);
    checks++;
    if (got !== exp) begin
      $display("Fail at %0t: %s = %0d, expected %0d", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      $display("Fail at %0t: %s = %b, expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_cfg(input string name, input cfg_t got, input cfg_t exp);
    checks++;
    if (got !== exp) begin
      $display("Fail at %0t: %s = size %0d chans %0d, expected size %0d chans %0d",
               $time, name, got.image_size, got.channel_num,
               exp.image_size, exp.channel_num);
      errors++;
    end
  endtask

  // Legal ranges of the configuration fields
  function automatic pix_idx_t clamp_size(input logic [31:0] v);
    if (v < MIN_PIXELS) return pix_idx_t'(MIN_PIXELS);
    if (v > MAX_PIXELS) return pix_idx_t'(MAX_PIXELS);
    return pix_idx_t'(v);
  endfunction

  function automatic chan_idx_t clamp_chans(input logic [31:0] v);
    if (v < 1) return chan_idx_t'(1);
    if (v > MAX_CHANNELS) return chan_idx_t'(MAX_CHANNELS);
    return chan_idx_t'(v);
  endfunction

  // Mix of full-range values and values near both ends
  function automatic pxl_t next_pixel();
    logic [31:0] r;
    r = $random(seed);
    if (r[1:0] == 2'd0) return pxl_t'({16'h7fff, r[31:16]});
    if (r[1:0] == 2'd1) return pxl_t'({16'h8000, r[31:16]});
    return pxl_t'(r);
  endfunction

  //////////////////////////////
  // Output monitor
  //////////////////////////////

  always @(negedge clk) begin
    if (reset === 1'b0 && mon_on) begin
      if (pxl_in.valid && last_chan_beat) exp_cycle_q.push_back(cyc + 2);
      expect_done = 1'b0;
      if (sum_out.valid) begin
        if (exp_cycle_q.size() == 0 || exp_sum_q.size() == 0) begin
          $display("Unexpected sum_out at %0t before the last channel", $time);
          errors++;
        end else begin
          exp_cycle = exp_cycle_q.pop_front();
          if (exp_cycle != cyc) begin
            $display("sum_out at %0t came in cycle %0d instead of cycle %0d",
                     $time, cyc, exp_cycle);
            errors++;
          end
          check_pxl("sum_out.data", sum_out.data, exp_sum_q.pop_front());
          out_cnt++;
          expect_done = (out_cnt == frame_size);
        end
      end
      check_flag("frame_done", frame_done, expect_done);
      if (frame_done) done_cnt++;
      // Busy from the cycle after the first beat to the cycle after frame_done
      check_flag("busy", busy, frame_open);
      if (pxl_in.valid) begin
        frame_open = 1'b1;
      end else if (frame_done) begin
        frame_open = 1'b0;
      end
    end
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  task automatic write_cfg(input cfg_addr_t addr, input logic [31:0] value);
    @(posedge clk);
    cfg_wr    <= 1'b1;
    cfg_addr  <= addr;
    cfg_wdata <= pxl_t'(value);
  endtask

  task automatic drive_frame(input int size, input int chans, input logic gap,
                             input logic mid_wr);
    int   c;
    int   p;
    int   beats;
    pxl_t value;
    beats = 0;
    for (c = 0; c < chans; c++) begin
      for (p = 0; p < size; p++) begin
        value = next_pixel();
        ref_sum[p] = (c == 0) ? value : ref_sum[p] + value;
        @(posedge clk);
        pxl_in         <= '{valid: 1'b1, data: value};
        last_chan_beat <= (c == chans - 1);
        if (c == chans - 1) exp_sum_q.push_back(ref_sum[p]);
        // Size change attempt while the frame runs
        if (mid_wr && c == 0 && p == 2) begin
          cfg_wr    <= 1'b1;
          cfg_addr  <= CFG_ADDR_IMAGE_SIZE;
          cfg_wdata <= pxl_t'(MID_SIZE);
        end else begin
          cfg_wr <= 1'b0;
        end
        beats++;
        if (gap && beats % 3 == 0) begin
          @(posedge clk);
          pxl_in         <= '0;
          last_chan_beat <= 1'b0;
          cfg_wr         <= 1'b0;
        end
      end
    end
    @(posedge clk);
    pxl_in         <= '0;
    last_chan_beat <= 1'b0;
    cfg_wr         <= 1'b0;
  endtask

  task automatic run_row(input int r);
    row_t row;
    cfg_t exp_cfg;
    int   start_err;
    int   start_done;
    int   wait_cnt;
    row = ROWS[r];
    start_err = errors;
    exp_cfg.image_size  = clamp_size(row.size_wr);
    exp_cfg.channel_num = clamp_chans(row.chan_wr);
    write_cfg(CFG_ADDR_IMAGE_SIZE, row.size_wr);
    write_cfg(CFG_ADDR_CHANNEL_NUM, row.chan_wr);
    @(posedge clk);
    cfg_wr <= 1'b0;
    @(negedge clk);
    check_cfg("cfg", uut.cfg, exp_cfg);
    frame_size = int'(exp_cfg.image_size);
    out_cnt = 0;
    start_done = done_cnt;
    drive_frame(frame_size, int'(exp_cfg.channel_num), row.gap, row.mid_wr);
    wait_cnt = 0;
    while (done_cnt == start_done && wait_cnt < DONE_TIMEOUT) begin
      @(posedge clk);
      wait_cnt++;
    end
    if (done_cnt == start_done) begin
      $display("Timeout in row %0d, frame_done never came", r);
      errors++;
    end
    if (out_cnt != frame_size || exp_sum_q.size() != 0) begin
      $display("Row %0d gave %0d sums, expected %0d", r, out_cnt, frame_size);
      errors++;
    end
    @(negedge clk);
    check_flag("busy", busy, 1'b0);
    // Same write once the frame is over
    if (row.mid_wr) begin
      write_cfg(CFG_ADDR_IMAGE_SIZE, MID_SIZE);
      @(posedge clk);
      cfg_wr <= 1'b0;
      @(negedge clk);
      exp_cfg.image_size = clamp_size(MID_SIZE);
      check_cfg("cfg", uut.cfg, exp_cfg);
    end
    $display("row %0d: size %0d, channels %0d, gap %0d, mid write %0d, %0d sums, %0d errors",
             r, exp_cfg.image_size, exp_cfg.channel_num, row.gap, row.mid_wr,
             out_cnt, errors - start_err);
  endtask

  initial begin
    reset          = 1'b1;
    cfg_wr         = 1'b0;
    cfg_addr       = '0;
    cfg_wdata      = '0;
    pxl_in         = '0;
    last_chan_beat = 1'b0;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    mon_on = 1'b1;
    @(negedge clk);
    check_flag("busy", busy, 1'b0);
    check_flag("sum_out.valid", sum_out.valid, 1'b0);
    check_cfg("cfg", uut.cfg, '{image_size: 7'd64, channel_num: 5'd16});
    for (row_idx = 0; row_idx < N_ROWS; row_idx++) begin
      run_row(row_idx);
    end
    $display("Rows %0d, checks %0d, errors %0d", N_ROWS, checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: channel_in_adder.f
rtl/acc_types_pkg.sv
rtl/acc_cfg_pkg.sv
rtl/acc_cfg_regs.sv
rtl/partial_sum_buffer.sv
rtl/sum_adder_stage.sv
rtl/channel_sum_ctrl.sv
rtl/channel_in_adder.sv
dv/channel_in_adder_assertions.sv
dv/channel_in_adder_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

LOG=sim.log
TOP=channel_in_adder_tb

verilator --binary --timing --assert -Wno-fatal \
  --top-module "$TOP" \
  -f channel_in_adder.f \
  -Mdir obj_dir -o sim_bin

status=0
./obj_dir/sim_bin > "$LOG" 2>&1 || status=$?
cat "$LOG"

if grep -q "test failed" "$LOG" || [ "$status" -ne 0 ]; then
  echo "Simulation reported failure, see $LOG"
  exit 1
fi

echo "Simulation finished without failures"
